// File: fpu_noncomp.f
+incdir+include
logic/fpu_noncomp_pkg.sv
logic/fpu_decoder.sv
logic/fpu_issue_buffer.sv
logic/fpu_sgnj_unit.sv
logic/fpu_cmp_unit.sv
logic/fpu_result_stage.sv
logic/fpu_noncomp_top.sv
tests/tb_fpu_noncomp.sv

// File: run.sh
#!/bin/sh
# Build and run the fpu_noncomp testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_fpu_noncomp \
    -f fpu_noncomp.f \
    -o sim_fpu_noncomp

./obj_dir/sim_fpu_noncomp | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
grep -q "TEST RESULT: PASS" sim.log

// File: include/tb_fpu_model.svh
// FPU reference model
`ifndef TB_FPU_MODEL_SVH
`define TB_FPU_MODEL_SVH

// Galois LFSR step for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

function automatic logic fp_is_nan(input logic [fpu_noncomp_pkg::FLEN-1:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != '0);
endfunction

function automatic logic fp_is_snan(input logic [fpu_noncomp_pkg::FLEN-1:0] x);
    return fp_is_nan(x) && !x[22];
endfunction

// Unsigned key in real-line order with -0 just below +0
function automatic logic [31:0] order_key(input logic [fpu_noncomp_pkg::FLEN-1:0] x);
    return x[31] ? ~x : (x | 32'h80000000);  // Negatives reversed below positives
endfunction

// Strict order on non-NaN values
function automatic logic fp_lt(input logic [fpu_noncomp_pkg::FLEN-1:0] a,
                               input logic [fpu_noncomp_pkg::FLEN-1:0] b);
    return order_key(a) < order_key(b);
endfunction

// Expected result and flags for one issue operation
function automatic void model_fpu(
    input  fpu_noncomp_pkg::fpu_op_e                op,
    input  logic [fpu_noncomp_pkg::RM_BITS-1:0]     rm,
    input  logic [fpu_noncomp_pkg::FLEN-1:0]        a,
    input  logic [fpu_noncomp_pkg::FLEN-1:0]        b,
    output logic [fpu_noncomp_pkg::FLEN-1:0]        res,
    output logic [fpu_noncomp_pkg::STATUS_BITS-1:0] status
);
    logic any_nan;
    logic eq;
    any_nan = fp_is_nan(a) || fp_is_nan(b);
    eq      = (a == b) || ((a[30:0] == '0) && (b[30:0] == '0));  // -0 equals +0
    res     = a;
    status  = '0;
    case (op)
        fpu_noncomp_pkg::FSGNJ: begin
            if (rm[1:0] == 2'b00) res = {b[31], a[30:0]};
            else if (rm[1:0] == 2'b01) res = {~b[31], a[30:0]};
            else if (rm[1:0] == 2'b10) res = {a[31] ^ b[31], a[30:0]};
        end
        fpu_noncomp_pkg::FMIN_MAX: begin
            status[fpu_noncomp_pkg::STATUS_NV] = fp_is_snan(a) || fp_is_snan(b);
            if (fp_is_nan(a) && fp_is_nan(b)) res = fpu_noncomp_pkg::CANON_NAN;
            else if (fp_is_nan(a)) res = b;
            else if (fp_is_nan(b)) res = a;
            else if (rm[0]) res = fp_lt(a, b) ? b : a;  // Max
            else res = fp_lt(b, a) ? b : a;  // Min
        end
        fpu_noncomp_pkg::FCMP: begin
            res = '0;
            if (rm[1:0] == 2'b00) res[0] = !any_nan && (fp_lt(a, b) || eq);
            else if (rm[1:0] == 2'b01) res[0] = !any_nan && fp_lt(a, b) && !eq;
            else if (rm[1:0] == 2'b10) res[0] = !any_nan && eq;
            if (rm[1] == 1'b0) status[fpu_noncomp_pkg::STATUS_NV] = any_nan;
            else if (rm[0] == 1'b0)
                status[fpu_noncomp_pkg::STATUS_NV] = fp_is_snan(a) || fp_is_snan(b);
        end
        default: ;  // Moves return operand a
    endcase
endfunction

`endif

// File: tests/tb_fpu_noncomp.sv
// FPU non-computational testbench
module tb_fpu_noncomp;
    timeunit 1ns;
    timeprecision 1ps;

    `include "tb_fpu_model.svh"

    localparam int unsigned TransIdBits = 3;
    localparam int unsigned NumOps      = 200;  // Per random test
    localparam int unsigned ResetCycles = 16;
    // Eight cycles for each op of two random tests and a few directed ops
    localparam int unsigned MaxCycles   = 8 * (2 * NumOps + 8) + ResetCycles;
    localparam int unsigned OutBits     = fpu_noncomp_pkg::FLEN + fpu_noncomp_pkg::STATUS_BITS
                                          + TransIdBits;

    typedef struct packed {
        logic [fpu_noncomp_pkg::FLEN-1:0]        result;
        logic [fpu_noncomp_pkg::STATUS_BITS-1:0] status;
        logic [TransIdBits-1:0]                  tag;
        logic [31:0]                             cycle;  // Edge of acceptance
    } expect_t;

    logic                                    clk_i;
    logic                                    rst_ni;
    logic                                    flush_i;
    logic                                    fpu_valid_i;
    logic                                    fpu_ready_o;
    fpu_noncomp_pkg::fu_data_t               fu_data_i;
    logic [fpu_noncomp_pkg::RM_BITS-1:0]     fpu_rm_i;
    logic [TransIdBits-1:0]                  fpu_trans_id_i;
    logic [fpu_noncomp_pkg::FLEN-1:0]        result_o;
    logic [fpu_noncomp_pkg::STATUS_BITS-1:0] fpu_status_o;
    logic [TransIdBits-1:0]                  fpu_trans_id_o;
    logic                                    fpu_valid_o;
    logic                                    out_ready_i;
    logic [OutBits-1:0]                      out_now;  // Whole output payload

    // ----------------------------------------
    // Testbench state
    // ----------------------------------------
    expect_t                expect_q[$];  // In-flight results with the oldest first
    logic [31:0]            lfsr      = 32'he52c1a34;
    logic [31:0]            cycle     = '0;
    logic [TransIdBits-1:0] next_tag  = '0;
    logic                   bp_mode   = 1'b0;  // Random out_ready_i
    logic                   lat_mode  = 1'b0;  // Expect one-cycle latency
    logic                   hold_seen = 1'b0;  // Result stalled at last edge
    logic [OutBits-1:0]     held_out;
    string                  test_name = "none";
    int                     err_cnt   = 0;     // Monitor side
    int                     chk_cnt   = 0;
    int                     stim_err  = 0;     // Stimulus side
    int                     stim_chk  = 0;
    int                     err_start = 0;
    int                     chk_start = 0;
    int                     n_tests   = 0;

    fpu_noncomp_top #(.TransIdBits(TransIdBits)) dut_i (
        .clk_i, .rst_ni, .flush_i, .fpu_valid_i, .fpu_ready_o, .fu_data_i, .fpu_rm_i,
        .fpu_trans_id_i, .result_o, .fpu_status_o, .fpu_trans_id_o, .fpu_valid_o, .out_ready_i
    );

    assign out_now = {result_o, fpu_status_o, fpu_trans_id_o};

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;  // 8 ns period
    end

    // ----------------------------------------
    // Random data
    // ----------------------------------------
    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] v;
        v = '0;
        for (int unsigned i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);  // One step per bit
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Half of the operands are special values
    function automatic logic [31:0] rand_operand();
        logic [2:0] pick;
        if (rand_bits(1) == 0) return rand_bits(32);
        pick = 3'(rand_bits(3));
        case (pick)
            3'd0:    return 32'h00000000;  // +0
            3'd1:    return 32'h80000000;  // -0
            3'd2:    return 32'h7fc00000;  // Quiet NaN
            3'd3:    return 32'h7f800001;  // Signaling NaN
            3'd4:    return 32'h7f800000;  // +inf
            3'd5:    return 32'hff800000;  // -inf
            3'd6:    return 32'hffa00000;  // Negative sNaN
            default: return 32'h3f800000;  // 1.0
        endcase
    endfunction

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    task automatic tick();
        @(posedge clk_i);
        if (bp_mode) out_ready_i <= 1'(rand_bits(1));  // Consumer stalls at random
    endtask

    task automatic drive_random();
        fpu_noncomp_pkg::fu_data_t pkt;
        logic [2:0]                sel;
        sel           = 3'(rand_bits(3) % 5);
        pkt.operation = fpu_noncomp_pkg::fpu_op_e'(sel);
        pkt.operand_a = rand_operand();
        // Equal operands now and then for eq and le
        pkt.operand_b = (rand_bits(3) == 0) ? pkt.operand_a : rand_operand();
        fpu_valid_i    <= 1'b1;
        fu_data_i      <= pkt;
        fpu_rm_i       <= 3'(rand_bits(3));  // Top bit exercises the mask
        fpu_trans_id_i <= next_tag;
    endtask

    // Issue side holds its inputs until the token comes back
    task automatic wait_accept();
        tick();
        while (!fpu_ready_o) tick();
        next_tag    = next_tag + 1'b1;
        fpu_valid_i <= 1'b0;
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        stim_chk++;
        if (act != exp) begin
            $display("Fail %s: %s expected %0b actual %0b", test_name, what, exp, act);
            stim_err++;
        end
    endtask

    task automatic start_test(input string name, input logic lat);
        @(negedge clk_i);
        test_name = name;
        lat_mode  = lat;
        err_start = err_cnt + stim_err;
        chk_start = chk_cnt + stim_chk;
        @(posedge clk_i);
    endtask

    task automatic end_test();
        @(negedge clk_i);
        while (expect_q.size() != 0) begin  // Drain the in-flight results
            tick();
            @(negedge clk_i);
        end
        lat_mode = 1'b0;
        n_tests++;
        $display("Test %s done: %0d checks, %0d errors", test_name,
                 chk_cnt + stim_chk - chk_start, err_cnt + stim_err - err_start);
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        rst_ni         = 1'b0;
        flush_i        = 1'b0;
        fpu_valid_i    = 1'b0;
        fu_data_i      = '0;
        fpu_rm_i       = '0;
        fpu_trans_id_i = '0;
        out_ready_i    = 1'b1;
        repeat (ResetCycles) @(posedge clk_i);
        rst_ni <= 1'b1;

        start_test("reset", 1'b0);
        @(negedge clk_i);
        check_bit("fpu_ready_o", 1'b1, fpu_ready_o);
        check_bit("fpu_valid_o", 1'b0, fpu_valid_o);
        end_test();

        // Back-to-back issue with the consumer always ready
        start_test("random_ops", 1'b1);
        repeat (NumOps) begin
            drive_random();
            wait_accept();
        end
        end_test();

        start_test("backpressure", 1'b0);
        bp_mode = 1'b1;
        repeat (NumOps) begin
            repeat (rand_bits(2)) tick();  // Idle issue slots
            drive_random();
            wait_accept();
        end
        end_test();
        bp_mode = 1'b0;

        start_test("flush", 1'b0);
        out_ready_i <= 1'b0;
        drive_random();
        wait_accept();  // Sits in the output register
        drive_random();  // Parks in the hold register
        repeat (2) tick();
        @(negedge clk_i);
        check_bit("fpu_ready_o while stalled", 1'b0, fpu_ready_o);
        @(posedge clk_i);
        fpu_valid_i <= 1'b0;
        flush_i     <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        @(negedge clk_i);
        check_bit("fpu_valid_o after flush", 1'b0, fpu_valid_o);
        check_bit("fpu_ready_o after flush", 1'b1, fpu_ready_o);
        @(posedge clk_i);
        out_ready_i <= 1'b1;
        drive_random();
        wait_accept();
        end_test();

        $display("Tests run %0d, checks %0d, errors %0d", n_tests, chk_cnt + stim_chk,
                 err_cnt + stim_err);
        if (err_cnt + stim_err == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // ----------------------------------------
    // Compare process and cycle limit
    // ----------------------------------------
    always @(posedge clk_i) begin : monitor
        logic [fpu_noncomp_pkg::FLEN-1:0]        exp_res;
        logic [fpu_noncomp_pkg::STATUS_BITS-1:0] exp_st;
        expect_t                                 item;
        cycle++;
        if (cycle > MaxCycles) begin
            $display("Timeout after %0d cycles in %s, %0d results still pending",
                     MaxCycles, test_name, expect_q.size());
            $display("TEST RESULT: FAIL");
            $finish;
        end else if (rst_ni) begin
            // Stalled result must stay put
            if (hold_seen && !fpu_valid_o) begin
                $display("fpu_valid_o dropped in %s while out_ready_i was low", test_name);
                err_cnt++;
            end else if (hold_seen && out_now != held_out) begin
                $display("Fail %s: held output expected %h actual %h", test_name,
                         held_out, out_now);
                err_cnt++;
            end
            hold_seen = fpu_valid_o && !out_ready_i && !flush_i;
            held_out  = out_now;

            if (lat_mode && fpu_valid_i && !fpu_ready_o) begin
                $display("fpu_ready_o went low in %s during back-to-back issue", test_name);
                err_cnt++;
            end

            if (fpu_valid_o && out_ready_i) begin
                if (expect_q.size() == 0) begin
                    $display("Result in %s with no operation pending", test_name);
                    err_cnt++;
                end else begin
                    item = expect_q.pop_front();
                    chk_cnt++;
                    if (fpu_trans_id_o != item.tag) begin
                        $display("Fail %s: trans_id expected %0d actual %0d, out of order",
                                 test_name, item.tag, fpu_trans_id_o);
                        err_cnt++;
                    end
                    if (result_o != item.result) begin
                        $display("Fail %s: result expected %h actual %h", test_name,
                                 item.result, result_o);
                        err_cnt++;
                    end
                    if (fpu_status_o != item.status) begin
                        $display("Fail %s: status expected %b actual %b", test_name,
                                 item.status, fpu_status_o);
                        err_cnt++;
                    end
                    if (lat_mode && cycle - item.cycle != 1) begin
                        $display("Fail %s: latency expected 1 actual %0d", test_name,
                                 cycle - item.cycle);
                        err_cnt++;
                    end
                end
            end

            if (flush_i) expect_q.delete();  // Pending result is dropped
            else if (fpu_valid_i && fpu_ready_o) begin
                model_fpu(fu_data_i.operation, fpu_rm_i, fu_data_i.operand_a,
                          fu_data_i.operand_b, exp_res, exp_st);
                item.result = exp_res;
                item.status = exp_st;
                item.tag    = fpu_trans_id_i;
                item.cycle  = cycle;
                expect_q.push_back(item);
            end
        end
    end

endmodule

// File: logic/fpu_noncomp_top.sv
// FPU non-computational top level
module fpu_noncomp_top #(
    parameter int unsigned TransIdBits = 3
) (
    input  logic                                    clk_i,
    input  logic                                    rst_ni,
    input  logic                                    flush_i,
    input  logic                                    fpu_valid_i,
    output logic                                    fpu_ready_o,
    input  fpu_noncomp_pkg::fu_data_t               fu_data_i,
    input  logic [fpu_noncomp_pkg::RM_BITS-1:0]     fpu_rm_i,
    input  logic [TransIdBits-1:0]                  fpu_trans_id_i,
    output logic [fpu_noncomp_pkg::FLEN-1:0]        result_o,
    output logic [fpu_noncomp_pkg::STATUS_BITS-1:0] fpu_status_o,
    output logic [TransIdBits-1:0]                  fpu_trans_id_o,
    output logic                                    fpu_valid_o,
    input  logic                                    out_ready_i
);

    fpu_noncomp_pkg::fpu_req_t  dec_req;  // Straight from issue
    fpu_noncomp_pkg::fpu_req_t  be_req;   // Towards back end
    logic [TransIdBits-1:0]     be_tag;
    logic                       be_valid;
    logic                       be_ready;
    fpu_noncomp_pkg::unit_res_t sgnj_res;
    fpu_noncomp_pkg::unit_res_t cmp_res;

    fpu_decoder u_decoder (.fu_data_i(fu_data_i), .rm_i(fpu_rm_i), .req_o(dec_req));

    fpu_issue_buffer #(.TransIdBits(TransIdBits)) u_issue_buffer (
        .clk_i, .rst_ni, .flush_i,
        .valid_i(fpu_valid_i), .ready_o(fpu_ready_o), .req_i(dec_req), .tag_i(fpu_trans_id_i),
        .in_valid_o(be_valid), .req_o(be_req), .tag_o(be_tag), .in_ready_i(be_ready)
    );

    // Both units see every request
    fpu_sgnj_unit u_sgnj (.req_i(be_req), .res_o(sgnj_res));
    fpu_cmp_unit  u_cmp  (.req_i(be_req), .res_o(cmp_res));

    fpu_result_stage #(.TransIdBits(TransIdBits)) u_result_stage (
        .clk_i, .rst_ni, .flush_i,
        .in_valid_i(be_valid), .in_ready_o(be_ready), .op_i(be_req.op), .tag_i(be_tag),
        .sgnj_i(sgnj_res), .cmp_i(cmp_res),
        .result_o(result_o), .status_o(fpu_status_o), .tag_o(fpu_trans_id_o),
        .valid_o(fpu_valid_o), .out_ready_i(out_ready_i)
    );

endmodule

// File: logic/fpu_result_stage.sv
// FPU output register stage
module fpu_result_stage #(
    parameter int unsigned TransIdBits = 3
) (
    input  logic                                    clk_i,
    input  logic                                    rst_ni,
    input  logic                                    flush_i,
    input  logic                                    in_valid_i,
    output logic                                    in_ready_o,
    input  fpu_noncomp_pkg::unit_op_e               op_i,
    input  logic [TransIdBits-1:0]                  tag_i,
    input  fpu_noncomp_pkg::unit_res_t              sgnj_i,
    input  fpu_noncomp_pkg::unit_res_t              cmp_i,
    output logic [fpu_noncomp_pkg::FLEN-1:0]        result_o,
    output logic [fpu_noncomp_pkg::STATUS_BITS-1:0] status_o,
    output logic [TransIdBits-1:0]                  tag_o,
    output logic                                    valid_o,
    input  logic                                    out_ready_i
);

    logic                       valid_q;
    logic                       load;  // Request taken this cycle
    fpu_noncomp_pkg::unit_res_t res_d, res_q;
    logic [TransIdBits-1:0]     tag_q;

    // Room when empty or when the current result leaves now
    assign in_ready_o = !valid_q || out_ready_i;
    assign load       = in_valid_i && in_ready_o;

    // Unit select
    assign res_d = (op_i == fpu_noncomp_pkg::UOP_SGNJ) ? sgnj_i : cmp_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) valid_q <= 1'b0;
        else if (flush_i) valid_q <= 1'b0;  // Drop pending result
        else if (load) valid_q <= 1'b1;
        else if (out_ready_i) valid_q <= 1'b0;
    end

    // Payload held while the consumer stalls
    always_ff @(posedge clk_i) begin
        if (load) begin
            res_q <= res_d;
            tag_q <= tag_i;
        end
    end

    assign result_o = res_q.result;
    assign status_o = res_q.status;
    assign tag_o    = tag_q;
    assign valid_o  = valid_q;

endmodule

// File: logic/fpu_cmp_unit.sv
// FP32 compare and min/max unit
module fpu_cmp_unit (
    input  fpu_noncomp_pkg::fpu_req_t  req_i,
    output fpu_noncomp_pkg::unit_res_t res_o
);

    logic [fpu_noncomp_pkg::FLEN-1:0] a, b;
    logic a_nan, b_nan;
    logic a_snan, b_snan;
    logic any_nan, any_snan;
    logic both_zero;  // +0 and -0 in any mix
    logic a_lt_b;     // Ordered, -0 below +0
    logic a_eq_b;     // Ordered, -0 equal to +0
    logic cmp_bit;

    assign a = req_i.operand_a;
    assign b = req_i.operand_b;

    // ----------------------------------------
    // Classification
    // ----------------------------------------
    assign a_nan    = (a[30:23] == 8'hff) && (a[22:0] != '0);
    assign b_nan    = (b[30:23] == 8'hff) && (b[22:0] != '0);
    assign a_snan   = a_nan && !a[22];  // Quiet bit clear
    assign b_snan   = b_nan && !b[22];
    assign any_nan  = a_nan || b_nan;
    assign any_snan = a_snan || b_snan;

    // Sign-magnitude ordering
    assign both_zero = (a[30:0] == '0) && (b[30:0] == '0);
    assign a_lt_b    = (a[31] != b[31]) ? a[31]
                     : (a[31] ? (a[30:0] > b[30:0]) : (a[30:0] < b[30:0]));
    assign a_eq_b    = (a == b) || both_zero;

    always_comb begin
        res_o.result = '0;
        res_o.status = '0;
        cmp_bit      = 1'b0;
        if (req_i.op == fpu_noncomp_pkg::UOP_CMP) begin
            unique case (req_i.rm)
                3'b000: cmp_bit = a_lt_b || a_eq_b;                // le
                3'b001: cmp_bit = a_lt_b && !both_zero;            // lt
                3'b010: cmp_bit = a_eq_b;                          // eq
                default: ;
            endcase
            // Signaling compares trap on any NaN, eq only on sNaN
            if (req_i.rm == 3'b000 || req_i.rm == 3'b001)
                res_o.status[fpu_noncomp_pkg::STATUS_NV] = any_nan;
            else if (req_i.rm == 3'b010)
                res_o.status[fpu_noncomp_pkg::STATUS_NV] = any_snan;
            res_o.result = {{(fpu_noncomp_pkg::FLEN-1){1'b0}}, cmp_bit && !any_nan};
        end else begin
            res_o.status[fpu_noncomp_pkg::STATUS_NV] = any_snan;
            if (a_nan && b_nan) res_o.result = fpu_noncomp_pkg::CANON_NAN;
            else if (a_nan) res_o.result = b;  // NaN loses to a number
            else if (b_nan) res_o.result = a;
            else res_o.result = (a_lt_b ^ req_i.rm[0]) ? a : b;  // rm[0] selects max
        end
    end

endmodule

// File: logic/fpu_sgnj_unit.sv
// FP32 sign injection unit
module fpu_sgnj_unit (
    input  fpu_noncomp_pkg::fpu_req_t  req_i,
    output fpu_noncomp_pkg::unit_res_t res_o
);

    localparam int unsigned SIGN = fpu_noncomp_pkg::FLEN - 1;

    logic                                sign_a;
    logic                                sign_b;
    logic [fpu_noncomp_pkg::FLEN-2:0]    mag_a;  // Magnitude kept from operand a

    assign sign_a = req_i.operand_a[SIGN];
    assign sign_b = req_i.operand_b[SIGN];
    assign mag_a  = req_i.operand_a[SIGN-1:0];

    always_comb begin
        unique case (req_i.rm)
            3'b000:  res_o.result = {sign_b, mag_a};           // fsgnj
            3'b001:  res_o.result = {~sign_b, mag_a};          // fsgnjn
            3'b010:  res_o.result = {sign_a ^ sign_b, mag_a};  // fsgnjx
            default: res_o.result = req_i.operand_a;           // Move passthrough
        endcase
        res_o.status = '0;  // Never raises flags
    end

endmodule

// File: logic/fpu_issue_buffer.sv
// Issue protocol inversion buffer
module fpu_issue_buffer #(
    parameter int unsigned TransIdBits = 3
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      flush_i,
    input  logic                      valid_i,
    output logic                      ready_o,
    input  fpu_noncomp_pkg::fpu_req_t req_i,
    input  logic [TransIdBits-1:0]    tag_i,
    output logic                      in_valid_o,
    output fpu_noncomp_pkg::fpu_req_t req_o,
    output logic [TransIdBits-1:0]    tag_o,
    input  logic                      in_ready_i
);

    typedef enum logic {
        READY,
        STALL
    } state_e;

    state_e                    state_q, state_d;
    logic                      hold_en;   // Capture request into hold register
    logic                      use_hold;  // Present held copy to back end
    fpu_noncomp_pkg::fpu_req_t req_q;
    logic [TransIdBits-1:0]    tag_q;

    // ----------------------------------------
    // FSM, valid towards back end follows ready
    // ----------------------------------------
    always_comb begin
        ready_o    = 1'b0;
        in_valid_o = 1'b0;
        hold_en    = 1'b0;
        use_hold   = 1'b0;
        state_d    = state_q;

        unique case (state_q)
            READY: begin
                ready_o    = 1'b1;     // Token offered to issue
                in_valid_o = valid_i;  // Pass straight through
                // Back end refuses, park the request
                if (valid_i && !in_ready_i) begin
                    ready_o = 1'b0;
                    hold_en = 1'b1;
                    state_d = STALL;
                end
            end
            STALL: begin
                in_valid_o = 1'b1;  // Held request pending
                use_hold   = 1'b1;
                if (in_ready_i) begin
                    ready_o = 1'b1;  // Issue handshake completes here
                    state_d = READY;
                end
            end
            default: state_d = READY;
        endcase

        if (flush_i) state_d = READY;  // Flush overrides everything
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) state_q <= READY;
        else state_q <= state_d;
    end

    // Hold register
    always_ff @(posedge clk_i) begin
        if (hold_en) begin
            req_q <= req_i;
            tag_q <= tag_i;
        end
    end

    assign req_o = use_hold ? req_q : req_i;
    assign tag_o = use_hold ? tag_q : tag_i;

endmodule

// File: logic/fpu_decoder.sv
// FPU operation decoder
module fpu_decoder (
    input  fpu_noncomp_pkg::fu_data_t                  fu_data_i,
    input  logic [fpu_noncomp_pkg::RM_BITS-1:0]        rm_i,
    output fpu_noncomp_pkg::fpu_req_t                  req_o
);

    // Sign injection passthrough, used by both moves
    localparam logic [fpu_noncomp_pkg::RM_BITS-1:0] RM_PASS = 3'b011;

    logic [fpu_noncomp_pkg::RM_BITS-1:0] rm_masked;

    // Top rm bit carries an alternate format encoding on the issue side
    assign rm_masked = {1'b0, rm_i[fpu_noncomp_pkg::RM_BITS-2:0]};

    always_comb begin
        // Defaults
        req_o.op        = fpu_noncomp_pkg::UOP_SGNJ;
        req_o.rm        = rm_i;
        req_o.operand_a = fu_data_i.operand_a;  // Operands never change here
        req_o.operand_b = fu_data_i.operand_b;

        unique case (fu_data_i.operation)
            // Sign injection, sub-op in rm 000..010
            fpu_noncomp_pkg::FSGNJ: begin
                req_o.op = fpu_noncomp_pkg::UOP_SGNJ;
                req_o.rm = rm_masked;
            end
            // Min/max, sub-op in rm 000..001
            fpu_noncomp_pkg::FMIN_MAX: begin
                req_o.op = fpu_noncomp_pkg::UOP_MINMAX;
                req_o.rm = rm_masked;
            end
            // Compare, sub-op in rm 000..010
            fpu_noncomp_pkg::FCMP: begin
                req_o.op = fpu_noncomp_pkg::UOP_CMP;
                req_o.rm = rm_masked;
            end
            fpu_noncomp_pkg::FMV_F2X: begin
                req_o.op = fpu_noncomp_pkg::UOP_SGNJ;  // Mapped onto passthrough
                req_o.rm = RM_PASS;
            end
            fpu_noncomp_pkg::FMV_X2F: begin
                req_o.op = fpu_noncomp_pkg::UOP_SGNJ;  // No recoding needed
                req_o.rm = RM_PASS;
            end
            default: ;  // Keep defaults
        endcase
    end

endmodule

// File: logic/fpu_noncomp_pkg.sv
// FPU non-computational definitions
package fpu_noncomp_pkg;

    // ----------------------------------------
    // Widths and constants
    // ----------------------------------------
    localparam int unsigned FLEN        = 32;  // Only FP32 is kept
    localparam int unsigned RM_BITS     = 3;   // Rounding mode field, reused as sub-op
    localparam int unsigned STATUS_BITS = 5;   // NV DZ OF UF NX
    localparam int unsigned STATUS_NV   = 4;   // Invalid operation flag

    // Canonical quiet NaN for FP32
    localparam logic [FLEN-1:0] CANON_NAN = 32'h7fc00000;

    // ----------------------------------------
    // Operation encodings
    // ----------------------------------------
    // Issue side operations
    typedef enum logic [2:0] {
        FSGNJ,     // Sign injection, variant in rm
        FMIN_MAX,  // Min or max, variant in rm
        FCMP,      // le, lt, eq, variant in rm
        FMV_F2X,   // Move FPR to GPR
        FMV_X2F    // Move GPR to FPR
    } fpu_op_e;

    // Unit side operations
    typedef enum logic [1:0] {
        UOP_SGNJ,    // Sign injection unit
        UOP_MINMAX,  // Compare unit, min/max path
        UOP_CMP      // Compare unit, compare path
    } unit_op_e;

    // ----------------------------------------
    // Packets
    // ----------------------------------------
    typedef struct packed {
        fpu_op_e         operation;
        logic [FLEN-1:0] operand_a;
        logic [FLEN-1:0] operand_b;
    } fu_data_t;

    // Request after translation
    typedef struct packed {
        unit_op_e           op;
        logic [RM_BITS-1:0] rm;  // Sub-operation
        logic [FLEN-1:0]    operand_a;
        logic [FLEN-1:0]    operand_b;
    } fpu_req_t;

    typedef struct packed {
        logic [FLEN-1:0]        result;
        logic [STATUS_BITS-1:0] status;
    } unit_res_t;

endpackage
